/* design/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  wire logic          clk,
  input  wire logic          rst,
  input  isa_pkg::word_t     instr,
  output logic               dmem_we,
  output logic               dmem_re,
  ctrl_if.ctrl               ctl
);

  typedef enum logic {IDLE, WAIT} state_t;

  state_t     state, next_state;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       wr;       // instruction writes rd
  logic       is_load;
  logic       is_store;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[isa_pkg::FUNCT7_ALT];

  always_comb begin
    ctl.alu_op      = core_pkg::ALU_ADD;
    ctl.src_imm     = 1'b0;
    ctl.is_unsigned = 1'b0;
    ctl.branch      = core_pkg::BR_NONE;
    ctl.wb_sel      = core_pkg::WB_ALU;
    ctl.imm_fmt     = isa_pkg::IMM_I;
    wr              = 1'b0;
    is_load         = 1'b0;
    is_store        = 1'b0;
    case (opcode)
      isa_pkg::OP, isa_pkg::OP_IMM: begin
        wr          = 1'b1;
        ctl.src_imm = (opcode == isa_pkg::OP_IMM);
        case (funct3)
          isa_pkg::F3_ADD_SUB: begin
            if (alt && opcode == isa_pkg::OP) ctl.alu_op = core_pkg::ALU_SUB; // no subi
          end
          isa_pkg::F3_SLL:  ctl.alu_op = core_pkg::ALU_SLL;
          isa_pkg::F3_SLT:  ctl.wb_sel = core_pkg::WB_LESS;
          isa_pkg::F3_SLTU: begin
            ctl.wb_sel      = core_pkg::WB_LESS;
            ctl.is_unsigned = 1'b1;
          end
          isa_pkg::F3_XOR:     ctl.alu_op = core_pkg::ALU_XOR;
          isa_pkg::F3_SRL_SRA: ctl.alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
          isa_pkg::F3_OR:      ctl.alu_op = core_pkg::ALU_OR;
          default:             ctl.alu_op = core_pkg::ALU_AND;
        endcase
      end
      isa_pkg::LOAD: begin
        if (funct3 == isa_pkg::F3_WORD) begin // lw only
          is_load     = 1'b1;
          ctl.src_imm = 1'b1;
          ctl.wb_sel  = core_pkg::WB_MEM;
        end
      end
      isa_pkg::STORE: begin
        if (funct3 == isa_pkg::F3_WORD) begin
          is_store    = 1'b1;
          ctl.src_imm = 1'b1;
          ctl.imm_fmt = isa_pkg::IMM_S;
        end
      end
      isa_pkg::BRANCH: begin
        ctl.imm_fmt = isa_pkg::IMM_B;
        case (funct3)
          isa_pkg::F3_BEQ:  ctl.branch = core_pkg::BR_EQ;
          isa_pkg::F3_BNE:  ctl.branch = core_pkg::BR_NE;
          isa_pkg::F3_BLT:  ctl.branch = core_pkg::BR_LT;
          isa_pkg::F3_BGE:  ctl.branch = core_pkg::BR_GE;
          isa_pkg::F3_BLTU: ctl.branch = core_pkg::BR_LTU;
          isa_pkg::F3_BGEU: ctl.branch = core_pkg::BR_GEU;
          default:          ctl.branch = core_pkg::BR_NONE;
        endcase
      end
      isa_pkg::JAL: begin
        wr          = 1'b1;
        ctl.branch  = core_pkg::BR_JUMP;
        ctl.wb_sel  = core_pkg::WB_LINK;
        ctl.imm_fmt = isa_pkg::IMM_J;
      end
      default: ; // retires as a no-op
    endcase
  end

  // memory ops stall the pc for one wait cycle
  always_comb begin
    next_state  = state;
    dmem_we     = 1'b0;
    dmem_re     = 1'b0;
    ctl.pc_en   = 1'b1;
    ctl.reg_we  = 1'b0;
    case (state)
      IDLE: begin
        if (is_load || is_store) begin
          dmem_re    = is_load;
          dmem_we    = is_store;
          ctl.pc_en  = 1'b0;
          next_state = WAIT;
        end else begin
          ctl.reg_we = wr;
        end
      end
      default: begin
        ctl.reg_we = is_load; // read data valid now
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

`default_nettype wire

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP // jal, always taken
  } branch_t;

  // writeback source
  typedef enum logic [1:0] {WB_ALU, WB_LESS, WB_MEM, WB_LINK} wb_sel_t;

endpackage

`default_nettype wire

/* design/ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if;
  core_pkg::alu_op_t  alu_op;
  logic               src_imm;     // operand b from immediate
  logic               is_unsigned; // sltu / sltiu
  core_pkg::branch_t  branch;
  core_pkg::wb_sel_t  wb_sel;
  isa_pkg::imm_fmt_t  imm_fmt;
  logic               reg_we;
  logic               pc_en;

  modport ctrl (output alu_op, src_imm, is_unsigned, branch, wb_sel, imm_fmt, reg_we, pc_en);
  modport exec (input alu_op, src_imm, is_unsigned, branch, wb_sel);
  modport regs (input reg_we);
  modport imm  (input imm_fmt);
  modport pc   (input pc_en);
endinterface

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  isa_pkg::word_t rs1_data,
  input  isa_pkg::word_t rs2_data,
  input  isa_pkg::word_t imm,
  input  isa_pkg::word_t pc_plus4,
  input  isa_pkg::word_t mem_data,
  ctrl_if.exec           ctl,
  output isa_pkg::word_t alu_sum,
  output isa_pkg::word_t wb_data,
  output logic           take_branch
);

  isa_pkg::word_t op_b;
  isa_pkg::word_t alu_res;
  logic           eq, lt_s, lt_u, less;

  assign op_b    = ctl.src_imm ? imm : rs2_data;
  assign alu_sum = rs1_data + op_b; // also the load/store address

  always_comb begin
    case (ctl.alu_op)
      core_pkg::ALU_SUB: alu_res = rs1_data - op_b;
      core_pkg::ALU_SLL: alu_res = rs1_data << op_b[4:0];
      core_pkg::ALU_SRL: alu_res = rs1_data >> op_b[4:0];
      core_pkg::ALU_SRA: alu_res = $signed(rs1_data) >>> op_b[4:0];
      core_pkg::ALU_AND: alu_res = rs1_data & op_b;
      core_pkg::ALU_OR:  alu_res = rs1_data | op_b;
      core_pkg::ALU_XOR: alu_res = rs1_data ^ op_b;
      default:           alu_res = alu_sum;
    endcase
  end

  // compares straight from the operands, no flags
  assign eq   = (rs1_data == op_b);
  assign lt_s = ($signed(rs1_data) < $signed(op_b));
  assign lt_u = (rs1_data < op_b);
  assign less = ctl.is_unsigned ? lt_u : lt_s;

  always_comb begin
    case (ctl.branch)
      core_pkg::BR_EQ:   take_branch = eq;
      core_pkg::BR_NE:   take_branch = !eq;
      core_pkg::BR_LT:   take_branch = lt_s;
      core_pkg::BR_GE:   take_branch = !lt_s;
      core_pkg::BR_LTU:  take_branch = lt_u;
      core_pkg::BR_GEU:  take_branch = !lt_u;
      core_pkg::BR_JUMP: take_branch = 1'b1;
      default:           take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (ctl.wb_sel)
      core_pkg::WB_LESS: wb_data = isa_pkg::word_t'(less);
      core_pkg::WB_MEM:  wb_data = mem_data;
      core_pkg::WB_LINK: wb_data = pc_plus4;
      default:           wb_data = alu_res;
    endcase
  end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
  input  isa_pkg::word_t instr,
  ctrl_if.imm            ctl,
  output isa_pkg::word_t imm
);

  always_comb begin
    case (ctl.imm_fmt)
      isa_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      isa_pkg::IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      isa_pkg::IMM_J: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:        imm = {{20{instr[31]}}, instr[31:20]}; // i-type
    endcase
  end

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes the core executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // alu funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_WORD = 3'b010; // lw / sw width

  localparam int FUNCT7_ALT = 30; // instr bit picking sub / sra

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} imm_fmt_t;

endpackage

`default_nettype wire

/* design/pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_unit #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  wire logic      clk,
  input  wire logic      rst,
  input  isa_pkg::word_t imm,
  input  wire logic      take_branch,
  ctrl_if.pc             ctl,
  output isa_pkg::word_t pc,
  output isa_pkg::word_t pc_plus4
);

  isa_pkg::word_t target;

  assign pc_plus4 = pc + 32'd4;
  assign target   = pc + imm; // branch / jal target

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (ctl.pc_en) begin // held during memory issue
      pc <= take_branch ? target : pc_plus4;
    end
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire logic         clk,
  input  wire logic         rst,
  input  isa_pkg::reg_addr_t rs1,
  input  isa_pkg::reg_addr_t rs2,
  input  isa_pkg::reg_addr_t rd,
  input  isa_pkg::word_t    wdata,
  ctrl_if.regs              ctl,
  output isa_pkg::word_t    rs1_data,
  output isa_pkg::word_t    rs2_data,
  output isa_pkg::word_t    x8
);

  localparam int NREGS = 1 << isa_pkg::REG_ADDR_W;

  isa_pkg::word_t regs [NREGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign x8       = regs[8]; // display register

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl.reg_we && rd != '0) begin // x0 stays zero
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter isa_pkg::word_t RESET_PC = '0
) (
  input  wire logic      clk,
  input  wire logic      rst,
  output isa_pkg::word_t imem_addr,
  input  isa_pkg::word_t imem_data,
  output isa_pkg::word_t dmem_addr,
  output isa_pkg::word_t dmem_wdata,
  output logic           dmem_we,
  output logic           dmem_re,
  input  isa_pkg::word_t dmem_rdata,
  output isa_pkg::word_t display_reg
);

  isa_pkg::word_t pc, pc_plus4;
  isa_pkg::word_t imm;
  isa_pkg::word_t rs1_data, rs2_data;
  isa_pkg::word_t wb_data;
  isa_pkg::word_t alu_sum;
  logic           take_branch;

  ctrl_if ctl ();

  assign imem_addr  = pc;
  assign dmem_addr  = alu_sum;
  assign dmem_wdata = rs2_data;

  control_unit i_control_unit (
    .clk     (clk),
    .rst     (rst),
    .instr   (imem_data),
    .dmem_we (dmem_we),
    .dmem_re (dmem_re),
    .ctl     (ctl)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (imem_data[19:15]),
    .rs2      (imem_data[24:20]),
    .rd       (imem_data[11:7]),
    .wdata    (wb_data),
    .ctl      (ctl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .x8       (display_reg)
  );

  imm_gen i_imm_gen (
    .instr (imem_data),
    .ctl   (ctl),
    .imm   (imm)
  );

  execute_unit i_execute_unit (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc_plus4    (pc_plus4),
    .mem_data    (dmem_rdata),
    .ctl         (ctl),
    .alu_sum     (alu_sum),
    .wb_data     (wb_data),
    .take_branch (take_branch)
  );

  pc_unit #(.RESET_PC(RESET_PC)) i_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .imm         (imm),
    .take_branch (take_branch),
    .ctl         (ctl),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
design/isa_pkg.sv
design/core_pkg.sv
design/ctrl_if.sv
design/control_unit.sv
design/execute_unit.sv
design/reg_file.sv
design/imm_gen.sv
design/pc_unit.sv
design/rv_core.sv
test/rv_core_assert.sv
test/tb_rv_core.sv

/* test/rv_core_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_assert (
  input wire logic      clk,
  input wire logic      rst,
  input wire logic      dmem_we,
  input wire logic      dmem_re,
  input isa_pkg::word_t imem_addr
);

  int fails = 0;

  strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(dmem_we && dmem_re))
    else begin
      $error("dmem_we and dmem_re high together");
      fails++;
    end

  // one-cycle strobes only
  strobe_single: assert property (@(posedge clk) disable iff (rst)
    (dmem_we || dmem_re) |=> !(dmem_we || dmem_re))
    else begin
      $error("memory strobe high on two consecutive cycles");
      fails++;
    end

  pc_held: assert property (@(posedge clk) disable iff (rst)
    (dmem_we || dmem_re) |=> $stable(imem_addr))
    else begin
      $error("pc moved in the cycle after a memory strobe");
      fails++;
    end

endmodule

bind rv_core rv_core_assert i_rv_core_assert (
  .clk       (clk),
  .rst       (rst),
  .dmem_we   (dmem_we),
  .dmem_re   (dmem_re),
  .imem_addr (imem_addr)
);

`default_nettype wire

/* test/rv_model.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

isa_pkg::word_t prog [PROG_LEN];
isa_pkg::word_t mregs [32];
isa_pkg::word_t mdmem [DMEM_WORDS];
isa_pkg::word_t mpc;

// initial data memory contents differ per word
function automatic isa_pkg::word_t fill_word(input int i);
  return {i[15:0], ~i[15:0]} ^ 32'h3c5a_0f96;
endfunction

function automatic isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                           input isa_pkg::word_t a, input isa_pkg::word_t b);
  case (f3)
    3'd0: begin
      if (alt) return a - b;
      return a + b;
    end
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic gen_program();
  isa_pkg::word_t ins;
  isa_pkg::word_t off;
  logic [2:0]     f3;
  logic [4:0]     rd, rs1, rs2;
  logic [11:0]    imm;
  int             span;
  for (int i = 0; i < PROG_LEN - 1; i++) begin
    f3   = 3'($urandom);
    rd   = ($urandom % 3 == 0) ? 5'd8 : 5'($urandom % 10); // favour the display register
    rs1  = 5'($urandom % 10);
    rs2  = 5'($urandom % 10);
    imm  = 12'($urandom);
    span = (PROG_LEN - 1 - i < 4) ? PROG_LEN - 1 - i : 4;
    off  = 4 * (1 + $urandom % span); // forward and inside the program
    case ($urandom % 12)
      0, 1, 2, 3: begin
        ins = {((imm[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00),
               rs2, rs1, f3, rd, isa_pkg::OP};
      end
      4, 5, 6: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {1'b0, imm[10] & (f3 == 3'd5), 5'b0, imm[4:0]}; // shamt only
        end
        ins = {imm, rs1, f3, rd, isa_pkg::OP_IMM};
      end
      7: begin
        imm = {4'b0, imm[5:0], 2'b0};
        ins = {imm, 5'd0, isa_pkg::F3_WORD, rd, isa_pkg::LOAD};
      end
      8: begin
        imm = {4'b0, imm[5:0], 2'b0};
        ins = {imm[11:5], rs2, 5'd0, isa_pkg::F3_WORD, imm[4:0], isa_pkg::STORE};
      end
      9, 10: begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2; // no branch kind there
        ins = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isa_pkg::BRANCH};
      end
      default: ins = {off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::JAL};
    endcase
    prog[i] = ins;
  end
  prog[0]            = {12'h5a3, 5'd0, 3'b000, 5'd8, isa_pkg::OP_IMM}; // addi x8, x0
  prog[PROG_LEN - 1] = {20'b0, 5'd0, isa_pkg::JAL};                    // jal x0, 0
endtask

task automatic reset_model();
  mpc = RESET_PC;
  for (int r = 0; r < 32; r++) begin
    mregs[r] = '0;
  end
  for (int w = 0; w < DMEM_WORDS; w++) begin
    mdmem[w] = fill_word(w);
  end
endtask

// executes the instruction at mpc
task automatic step_model(output logic mem_op, output logic st,
                          output isa_pkg::word_t addr, output isa_pkg::word_t sdata);
  isa_pkg::word_t ins, a, b, res, nxt;
  logic           taken;
  ins    = prog[(mpc - RESET_PC) >> 2];
  a      = mregs[ins[19:15]];
  b      = mregs[ins[24:20]];
  res    = '0;
  nxt    = mpc + 4;
  mem_op = 1'b0;
  st     = 1'b0;
  addr   = '0;
  sdata  = '0;
  taken  = 1'b0;
  case (ins[6:0])
    isa_pkg::OP: res = alu_ref(ins[14:12], ins[30], a, b);
    isa_pkg::OP_IMM: begin
      res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a,
                    {{20{ins[31]}}, ins[31:20]});
    end
    isa_pkg::LOAD: begin
      mem_op = 1'b1;
      addr   = a + {{20{ins[31]}}, ins[31:20]};
      res    = mdmem[addr[7:2]];
    end
    isa_pkg::STORE: begin
      mem_op = 1'b1;
      st     = 1'b1;
      addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      sdata  = b;
      mdmem[addr[7:2]] = b;
    end
    isa_pkg::BRANCH: begin
      case (ins[14:12])
        3'd0: taken = (a == b);
        3'd1: taken = (a != b);
        3'd4: taken = ($signed(a) < $signed(b));
        3'd5: taken = ($signed(a) >= $signed(b));
        3'd6: taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) nxt = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    end
    isa_pkg::JAL: begin
      res = mpc + 4;
      nxt = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    default: ;
  endcase
  if (ins[6:0] inside {isa_pkg::OP, isa_pkg::OP_IMM, isa_pkg::LOAD, isa_pkg::JAL} &&
      ins[11:7] != 5'd0) begin
    mregs[ins[11:7]] = res;
  end
  mpc = nxt;
endtask

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam isa_pkg::word_t RESET_PC = 32'h0000_0100;
  localparam int PROG_LEN   = 64;
  localparam int DMEM_WORDS = 64;
  localparam int WATCHDOG_NS = (16 + 2 * PROG_LEN + 20) * 20;
  localparam logic [31:0] SEED = 32'h67c2_7cdc;

  logic           clk;
  logic           rst;
  logic           dmem_we, dmem_re;
  isa_pkg::word_t imem_addr, imem_data, imem_idx;
  isa_pkg::word_t dmem_addr, dmem_wdata, dmem_rdata, display_reg;
  isa_pkg::word_t dmem [DMEM_WORDS];
  isa_pkg::word_t rd_q;
  int             errors;
  int             retired;

  `include "rv_model.svh"

  rv_core #(.RESET_PC(RESET_PC)) i_rv_core (
    .clk         (clk),
    .rst         (rst),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_we     (dmem_we),
    .dmem_re     (dmem_re),
    .dmem_rdata  (dmem_rdata),
    .display_reg (display_reg)
  );

  always #10 clk = ~clk;

  // combinational instruction memory with nops past the program
  assign imem_idx  = (imem_addr - RESET_PC) >> 2;
  assign imem_data = (imem_idx < PROG_LEN) ? prog[imem_idx] : 32'h0000_0013;

  // data memory with registered read data
  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
    if (dmem_re) begin
      rd_q = dmem[dmem_addr[7:2]];
      #2 dmem_rdata = rd_q;
    end
  end

  task automatic report_mismatch(input string what, input isa_pkg::word_t got,
                                 input isa_pkg::word_t exp);
    errors++;
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t: the program did not reach its final jump", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic           mem_op, st;
    isa_pkg::word_t exp_addr, exp_data, issue_pc;
    int             afails;
    clk        = 1'b0;
    rst        = 1'b1;
    dmem_rdata = '0;
    errors     = 0;
    retired    = 0;
    void'($urandom(SEED));
    gen_program();
    reset_model();
    for (int w = 0; w < DMEM_WORDS; w++) begin
      dmem[w] = fill_word(w);
    end
    repeat (16) @(posedge clk);
    #2;
    if (imem_addr !== RESET_PC) report_mismatch("imem_addr after reset", imem_addr, RESET_PC);
    if (dmem_we !== 1'b0) report_mismatch("dmem_we after reset", dmem_we, 0);
    if (dmem_re !== 1'b0) report_mismatch("dmem_re after reset", dmem_re, 0);
    rst = 1'b0;

    while (mpc != RESET_PC + 4 * (PROG_LEN - 1)) begin
      if (imem_addr !== mpc) report_mismatch("imem_addr", imem_addr, mpc);
      issue_pc = mpc;
      step_model(mem_op, st, exp_addr, exp_data);
      if (mem_op) begin
        if (dmem_we !== st) report_mismatch("dmem_we at issue", dmem_we, st);
        if (dmem_re !== !st) report_mismatch("dmem_re at issue", dmem_re, !st);
        if (dmem_addr !== exp_addr) report_mismatch("memory address", dmem_addr, exp_addr);
        if (st && dmem_wdata !== exp_data) report_mismatch("store data", dmem_wdata, exp_data);
        @(posedge clk);
        #2;
        if (imem_addr !== issue_pc) report_mismatch("imem_addr in wait", imem_addr, issue_pc);
        if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
          report_mismatch("strobes in wait", {dmem_we, dmem_re}, 0);
        end
      end else if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
        report_mismatch("strobes", {dmem_we, dmem_re}, 0);
      end
      @(posedge clk);
      #2;
      retired++;
      if (display_reg !== mregs[8]) report_mismatch("display_reg", display_reg, mregs[8]);
    end
    if (imem_addr !== mpc) report_mismatch("final imem_addr", imem_addr, mpc);
    @(posedge clk);
    #2;
    if (imem_addr !== mpc) report_mismatch("imem_addr on final jump", imem_addr, mpc);

    afails = i_rv_core.i_rv_core_assert.fails;
    $display("retired %0d instructions, %0d errors, %0d assertion failures",
             retired, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
